// File: src/dma_pkg.sv
// Shared widths, vector types, job and burst structs, register map and FSM state enums
package dma_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  // Lengths and strides are in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;
    addr_t src_stride;
    addr_t dst_stride;
    data_t reps;
  } dma_job_t;

  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;
  } dma_burst_t;

  // Register byte offsets
  typedef enum logic [5:0] {
    REG_SRC        = 6'h00,
    REG_DST        = 6'h04,
    REG_LEN        = 6'h08,
    REG_CONF       = 6'h0C,
    REG_SRC_STRIDE = 6'h10,
    REG_DST_STRIDE = 6'h14,
    REG_REPS       = 6'h18,
    REG_NEXT_ID    = 6'h1C,
    REG_DONE_ID    = 6'h20,
    REG_STATUS     = 6'h24
  } dma_reg_e;

  typedef enum logic [1:0] {ME_IDLE, ME_ISSUE, ME_WAIT} midend_state_e;

  typedef enum logic [1:0] {BE_IDLE, BE_RD_REQ, BE_RD_WAIT, BE_WR_REQ} backend_state_e;

endpackage

// File: src/dma_burst_if.sv
// Burst channel between midend and backend, with completion pulse
`timescale 1ns/1ps

interface dma_burst_if;

  import dma_pkg::*;

  logic       valid;
  logic       ready;
  dma_burst_t burst;
  // One pulse per finished burst
  logic       done;

  modport midend (
    output valid, burst,
    input  ready, done
  );

  modport backend (
    input  valid, burst,
    output ready, done
  );

endinterface

// File: src/dma_reg_frontend.sv
// Register frontend: config registers, job launch on NEXT_ID read, status readback
`timescale 1ns/1ps

module dma_reg_frontend (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_req_i,
  input  logic               reg_we_i,
  input  dma_pkg::dma_reg_e  reg_addr_i,
  input  dma_pkg::data_t     reg_wdata_i,
  output dma_pkg::data_t     reg_rdata_o,
  input  dma_pkg::id_t       next_id_i,
  input  dma_pkg::id_t       done_id_i,
  output logic               job_valid_o,
  output dma_pkg::dma_job_t  job_o,
  input  logic               job_ready_i,
  input  logic               fifo_empty_i,
  input  logic               midend_busy_i
);

  import dma_pkg::*;

  addr_t src_q;
  addr_t dst_q;
  addr_t len_q;
  addr_t src_stride_q;
  addr_t dst_stride_q;
  data_t reps_q;
  logic  twod_q;

  logic  launch_ok;
  logic  next_id_rd;
  logic  busy;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
      twod_q       <= 1'b0;
    end else if (reg_req_i && reg_we_i) begin
      case (reg_addr_i)
        REG_SRC:        src_q        <= reg_wdata_i;
        REG_DST:        dst_q        <= reg_wdata_i;
        REG_LEN:        len_q        <= reg_wdata_i;
        REG_CONF:       twod_q       <= reg_wdata_i[0];
        REG_SRC_STRIDE: src_stride_q <= reg_wdata_i;
        REG_DST_STRIDE: dst_stride_q <= reg_wdata_i;
        REG_REPS:       reps_q       <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Zero length or zero reps in 2D mode is never launched
  assign launch_ok  = (len_q != '0) && (!twod_q || (reps_q != '0));
  assign next_id_rd = reg_req_i && !reg_we_i && (reg_addr_i == REG_NEXT_ID);

  // Held only for the read cycle, so wait for ready before raising valid
  assign job_valid_o = next_id_rd && launch_ok && job_ready_i;

  assign job_o.src        = src_q;
  assign job_o.dst        = dst_q;
  assign job_o.len        = len_q;
  assign job_o.src_stride = src_stride_q;
  assign job_o.dst_stride = dst_stride_q;
  assign job_o.reps       = twod_q ? reps_q : data_t'(1);

  assign busy = !fifo_empty_i || midend_busy_i;

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      REG_SRC:        reg_rdata_o = src_q;
      REG_DST:        reg_rdata_o = dst_q;
      REG_LEN:        reg_rdata_o = len_q;
      REG_CONF:       reg_rdata_o = {{(DataWidth-1){1'b0}}, twod_q};
      REG_SRC_STRIDE: reg_rdata_o = src_stride_q;
      REG_DST_STRIDE: reg_rdata_o = dst_stride_q;
      REG_REPS:       reg_rdata_o = reps_q;
      REG_NEXT_ID: begin
        // Rejected launch reads back as 0
        if (job_valid_o) begin
          reg_rdata_o = next_id_i;
        end
      end
      REG_DONE_ID:    reg_rdata_o = done_id_i;
      REG_STATUS:     reg_rdata_o = {{(DataWidth-1){1'b0}}, busy};
      default: ;
    endcase
  end

endmodule

// File: src/dma_transfer_id_gen.sv
// Transfer ID counters for issued and retired jobs
`timescale 1ns/1ps

module dma_transfer_id_gen (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          issue_i,
  input  logic          retire_i,
  output dma_pkg::id_t  next_id_o,
  output dma_pkg::id_t  done_id_o
);

  import dma_pkg::*;

  id_t next_q;
  id_t done_q;

  // IDs start at 1, so done_q equals the last retired ID
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_q <= id_t'(1);
      done_q <= '0;
    end else begin
      if (issue_i) next_q <= next_q + id_t'(1);
      if (retire_i) done_q <= done_q + id_t'(1);
    end
  end

  assign next_id_o = next_q;
  assign done_id_o = done_q;

endmodule

// File: src/dma_job_fifo.sv
// Job FIFO as a circular buffer with fill counter and valid/ready ports
`timescale 1ns/1ps

module dma_job_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  dma_pkg::dma_job_t  data_i,
  output logic               valid_o,
  input  logic               ready_i,
  output dma_pkg::dma_job_t  data_o,
  output logic               empty_o
);

  import dma_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  dma_job_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push, pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign empty_o = !valid_o;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      if (push && !pop) count_q <= count_q + CntWidth'(1);
      else if (pop && !push) count_q <= count_q - CntWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: src/dma_nd_midend.sv
// 2D midend: splits a job into strided bursts, retires it after the last one
`timescale 1ns/1ps

module dma_nd_midend (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               job_valid_i,
  output logic               job_ready_o,
  input  dma_pkg::dma_job_t  job_i,
  output logic               job_done_o,
  output logic               busy_o,
  dma_burst_if.midend        bus
);

  import dma_pkg::*;

  midend_state_e state_q;
  addr_t         src_q, dst_q;
  addr_t         len_q, src_stride_q, dst_stride_q;
  data_t         reps_q;
  logic          job_done_q;

  assign job_ready_o = (state_q == ME_IDLE);
  assign busy_o      = (state_q != ME_IDLE);
  assign job_done_o  = job_done_q;

  assign bus.valid     = (state_q == ME_ISSUE);
  assign bus.burst.src = src_q;
  assign bus.burst.dst = dst_q;
  assign bus.burst.len = len_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ME_IDLE;
      reps_q     <= '0;
      job_done_q <= 1'b0;
    end else begin
      job_done_q <= 1'b0;
      case (state_q)
        ME_IDLE: begin
          if (job_valid_i) begin
            reps_q  <= job_i.reps;
            state_q <= ME_ISSUE;
          end
        end
        ME_ISSUE: begin
          if (bus.ready) state_q <= ME_WAIT;
        end
        ME_WAIT: begin
          if (bus.done) begin
            reps_q <= reps_q - data_t'(1);
            if (reps_q == data_t'(1)) begin
              job_done_q <= 1'b1;
              state_q    <= ME_IDLE;
            end else begin
              state_q <= ME_ISSUE;
            end
          end
        end
        default: state_q <= ME_IDLE;
      endcase
    end
  end

  // Burst addresses step by the strides after each completion
  always_ff @(posedge clk_i) begin
    if (job_valid_i && job_ready_o) begin
      src_q        <= job_i.src;
      dst_q        <= job_i.dst;
      len_q        <= job_i.len;
      src_stride_q <= job_i.src_stride;
      dst_stride_q <= job_i.dst_stride;
    end else if (state_q == ME_WAIT && bus.done) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

endmodule

// File: src/dma_backend.sv
// Word-copy backend: one read then one write per word over a req/gnt memory port
`timescale 1ns/1ps

module dma_backend (
  input  logic            clk_i,
  input  logic            arst_n_i,
  dma_burst_if.backend    bus,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output dma_pkg::addr_t  mem_addr_o,
  output dma_pkg::data_t  mem_wdata_o,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  dma_pkg::data_t  mem_rdata_i
);

  import dma_pkg::*;

  localparam addr_t WordBytes = addr_t'(DataWidth / 8);

  backend_state_e state_q;
  addr_t          src_q, dst_q;
  addr_t          rem_q;
  data_t          data_q;
  logic           done_q;

  assign bus.ready = (state_q == BE_IDLE);
  assign bus.done  = done_q;

  assign mem_req_o   = (state_q == BE_RD_REQ) || (state_q == BE_WR_REQ);
  assign mem_we_o    = (state_q == BE_WR_REQ);
  assign mem_addr_o  = (state_q == BE_WR_REQ) ? dst_q : src_q;
  assign mem_wdata_o = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BE_IDLE;
      rem_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        BE_IDLE: begin
          if (bus.valid) begin
            rem_q   <= bus.burst.len;
            state_q <= BE_RD_REQ;
          end
        end
        BE_RD_REQ: begin
          if (mem_gnt_i) state_q <= BE_RD_WAIT;
        end
        BE_RD_WAIT: begin
          if (mem_rvalid_i) state_q <= BE_WR_REQ;
        end
        BE_WR_REQ: begin
          if (mem_gnt_i) begin
            rem_q <= rem_q - WordBytes;
            // Last word written
            if (rem_q == WordBytes) begin
              done_q  <= 1'b1;
              state_q <= BE_IDLE;
            end else begin
              state_q <= BE_RD_REQ;
            end
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BE_IDLE && bus.valid) begin
      src_q <= bus.burst.src;
      dst_q <= bus.burst.dst;
    end else if (state_q == BE_WR_REQ && mem_gnt_i) begin
      src_q <= src_q + WordBytes;
      dst_q <= dst_q + WordBytes;
    end
    if (state_q == BE_RD_WAIT && mem_rvalid_i) data_q <= mem_rdata_i;
  end

endmodule

// File: src/dma_subsys.sv
// DMA subsystem top: frontend, ID counters, job FIFO, midend and backend
`timescale 1ns/1ps

module dma_subsys #(
  parameter int unsigned JobFifoDepth = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            reg_req_i,
  input  logic            reg_we_i,
  input  logic [5:0]      reg_addr_i,
  input  dma_pkg::data_t  reg_wdata_i,
  output dma_pkg::data_t  reg_rdata_o,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output dma_pkg::addr_t  mem_addr_o,
  output dma_pkg::data_t  mem_wdata_o,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  dma_pkg::data_t  mem_rdata_i
);

  import dma_pkg::*;

  // Frontend to FIFO
  dma_job_t fe_job;
  logic     fe_job_valid, fe_job_ready;

  // FIFO to midend
  dma_job_t me_job;
  logic     me_job_valid, me_job_ready;

  logic     fifo_empty, me_busy, me_job_done;
  logic     issue;
  id_t      next_id, done_id;

  dma_burst_if burst_bus ();

  assign issue = fe_job_valid && fe_job_ready;

  dma_reg_frontend i_frontend (
    .clk_i,
    .arst_n_i,
    .reg_req_i,
    .reg_we_i,
    .reg_addr_i    ( dma_reg_e'(reg_addr_i) ),
    .reg_wdata_i,
    .reg_rdata_o,
    .next_id_i     ( next_id      ),
    .done_id_i     ( done_id      ),
    .job_valid_o   ( fe_job_valid ),
    .job_o         ( fe_job       ),
    .job_ready_i   ( fe_job_ready ),
    .fifo_empty_i  ( fifo_empty   ),
    .midend_busy_i ( me_busy      )
  );

  dma_transfer_id_gen i_id_gen (
    .clk_i,
    .arst_n_i,
    .issue_i   ( issue       ),
    .retire_i  ( me_job_done ),
    .next_id_o ( next_id     ),
    .done_id_o ( done_id     )
  );

  dma_job_fifo #(
    .Depth ( JobFifoDepth )
  ) i_job_fifo (
    .clk_i,
    .arst_n_i,
    .valid_i ( fe_job_valid ),
    .ready_o ( fe_job_ready ),
    .data_i  ( fe_job       ),
    .valid_o ( me_job_valid ),
    .ready_i ( me_job_ready ),
    .data_o  ( me_job       ),
    .empty_o ( fifo_empty   )
  );

  dma_nd_midend i_midend (
    .clk_i,
    .arst_n_i,
    .job_valid_i ( me_job_valid ),
    .job_ready_o ( me_job_ready ),
    .job_i       ( me_job       ),
    .job_done_o  ( me_job_done  ),
    .busy_o      ( me_busy      ),
    .bus         ( burst_bus    )
  );

  dma_backend i_backend (
    .clk_i,
    .arst_n_i,
    .bus ( burst_bus ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i
  );

endmodule

// File: verification/tb_clk_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HalfPeriod  = 50,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: verification/tb_dma_subsys.sv
// DMA subsystem testbench: memory model, LFSR, check task, directed tests and timeout
`timescale 1ns/1ps

module tb_dma_subsys;

  import dma_pkg::*;

  localparam int JobFifoDepth = 4;
  localparam int MemWords     = 1024;
  localparam int MaxCycles    = 20000;

  logic        clk;
  logic        arst_n;
  logic        reg_req    = 1'b0;
  logic        reg_we     = 1'b0;
  logic [5:0]  reg_addr   = '0;
  logic [31:0] reg_wdata  = '0;
  logic [31:0] reg_rdata;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_gnt    = 1'b0;
  logic        mem_rvalid = 1'b0;
  logic [31:0] mem_rdata  = '0;

  logic [31:0] mem     [MemWords];
  logic [31:0] exp_mem [MemWords];
  logic [31:0] lfsr_q     = 32'hc887f2f0;
  logic        grant_hold = 1'b0;
  logic [31:0] exp_id     = 32'd1;

  // Access granted at the last rising edge
  logic        acc_pend = 1'b0;
  logic        acc_we   = 1'b0;
  logic [9:0]  acc_idx  = '0;
  logic [31:0] acc_data = '0;

  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int tests  = 0;

  tb_clk_gen i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  dma_subsys #(
    .JobFifoDepth ( JobFifoDepth )
  ) dut (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .reg_req_i    ( reg_req    ),
    .reg_we_i     ( reg_we     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_rdata_o  ( reg_rdata  ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Memory model: random grants, read data one cycle after the grant
  always @(negedge clk) begin
    mem_rvalid = 1'b0;
    if (acc_pend) begin
      if (acc_we) begin
        mem[acc_idx] = acc_data;
      end else begin
        mem_rvalid = 1'b1;
        mem_rdata  = mem[acc_idx];
      end
    end
    acc_pend = 1'b0;
    if (mem_req && !grant_hold && random_bits(1) == 32'd1) begin
      acc_pend = 1'b1;
      acc_we   = mem_we;
      acc_idx  = mem_addr[11:2];
      acc_data = mem_wdata;
    end
    mem_gnt = acc_pend;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at time %0t: %s: got %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Register access tasks start and end on a falling edge
  task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
    reg_req   = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_req = 1'b0;
    reg_we  = 1'b0;
  endtask

  task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
    reg_req  = 1'b1;
    reg_we   = 1'b0;
    reg_addr = addr;
    #10;
    data = reg_rdata;
    @(negedge clk);
    reg_req = 1'b0;
  endtask

  task automatic read_check(input logic [5:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] v;
    reg_read(addr, v);
    check(v, expected, what);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic fill_random(input logic [31:0] base, input int words);
    logic [31:0] a;
    logic [31:0] v;
    for (int i = 0; i < words; i++) begin
      a = base + i * 4;
      v = random_bits(32);
      mem[a[11:2]]     = v;
      exp_mem[a[11:2]] = v;
    end
  endtask

  // Expected memory after a job: reps bursts of len bytes, strided
  task automatic apply_copy(input logic [31:0] src, dst, len, ss, ds, reps);
    logic [31:0] s;
    logic [31:0] d;
    for (logic [31:0] k = 0; k < reps; k++) begin
      for (logic [31:0] w = 0; w < len / 4; w++) begin
        s = src + ss * k + w * 4;
        d = dst + ds * k + w * 4;
        exp_mem[d[11:2]] = exp_mem[s[11:2]];
      end
    end
  endtask

  task automatic compare_memory(input string what);
    for (int i = 0; i < MemWords; i++) begin
      check(mem[i[9:0]], exp_mem[i[9:0]], $sformatf("%s, word %0d", what, i));
    end
  endtask

  task automatic wait_done_id(input logic [31:0] id);
    logic [31:0] v;
    v = 32'd0;
    while (v != id) begin
      reg_read(REG_DONE_ID, v);
    end
  endtask

  task automatic program_job(input logic [31:0] src, dst, len, input logic twod,
                             input logic [31:0] ss, ds, reps);
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_LEN, len);
    reg_write(REG_CONF, {31'b0, twod});
    reg_write(REG_SRC_STRIDE, ss);
    reg_write(REG_DST_STRIDE, ds);
    reg_write(REG_REPS, reps);
  endtask

  // Accepted only with nonzero length, and nonzero reps in 2D mode
  task automatic launch_job(input logic [31:0] src, dst, len, input logic twod,
                            input logic [31:0] ss, ds, reps);
    logic [31:0] v;
    program_job(src, dst, len, twod, ss, ds, reps);
    reg_read(REG_NEXT_ID, v);
    if (len != 0 && (!twod || reps != 0)) begin
      check(v, exp_id, "ID of accepted launch");
      apply_copy(src, dst, len, ss, ds, twod ? reps : 32'd1);
      exp_id = exp_id + 32'd1;
    end else begin
      check(v, 32'd0, "rejected launch");
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests++;
    if (errors == mark) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - mark);
  endtask

  task automatic test_register_readback();
    int mark;
    mark = errors;
    read_check(REG_DONE_ID, 32'd0, "DONE_ID after reset");
    read_check(REG_STATUS, 32'd0, "STATUS after reset");
    program_job(32'h0000_0a40, 32'h0000_0c80, 32'd40, 1'b1, 32'd64, 32'd32, 32'd3);
    read_check(REG_SRC, 32'h0000_0a40, "SRC readback");
    read_check(REG_DST, 32'h0000_0c80, "DST readback");
    read_check(REG_LEN, 32'd40, "LEN readback");
    read_check(REG_CONF, 32'd1, "CONF readback");
    read_check(REG_SRC_STRIDE, 32'd64, "SRC_STRIDE readback");
    read_check(REG_DST_STRIDE, 32'd32, "DST_STRIDE readback");
    read_check(REG_REPS, 32'd3, "REPS readback");
    report_test("register readback", mark);
  endtask

  task automatic test_copy_1d();
    int mark;
    mark = errors;
    fill_random(32'h100, 8);
    launch_job(32'h100, 32'h200, 32'd32, 1'b0, 32'd0, 32'd0, 32'd0);
    wait_done_id(32'd1);
    compare_memory("1D copy");
    report_test("1D copy", mark);
  endtask

  task automatic test_copy_2d();
    int mark;
    mark = errors;
    fill_random(32'h400, 52);
    launch_job(32'h400, 32'h600, 32'd16, 1'b1, 32'd64, 32'd32, 32'd4);
    wait_done_id(exp_id - 32'd1);
    compare_memory("2D copy");
    report_test("2D copy", mark);
  endtask

  task automatic test_launch_reject();
    int mark;
    mark = errors;
    launch_job(32'h100, 32'h300, 32'd0, 1'b0, 32'd0, 32'd0, 32'd0);
    read_check(REG_DONE_ID, exp_id - 32'd1, "DONE_ID after zero length");
    launch_job(32'h100, 32'h300, 32'd16, 1'b1, 32'd0, 32'd0, 32'd0);
    read_check(REG_DONE_ID, exp_id - 32'd1, "DONE_ID after zero reps");
    launch_job(32'h100, 32'h300, 32'd16, 1'b1, 32'd0, 32'd0, 32'd1);
    wait_done_id(exp_id - 32'd1);
    compare_memory("after rejections");
    report_test("launch rejection", mark);
  endtask

  task automatic test_queueing();
    logic [31:0] dst;
    int          mark;
    mark = errors;
    fill_random(32'h800, 2);
    program_job(32'h800, 32'ha00, 32'd8, 1'b0, 32'd0, 32'd0, 32'd0);
    grant_hold = 1'b1;
    // One job in the midend, the rest fill the FIFO
    for (int j = 0; j <= JobFifoDepth; j++) begin
      dst = 32'ha00 + j * 32'h20;
      reg_write(REG_DST, dst);
      idle(2);
      read_check(REG_NEXT_ID, exp_id, $sformatf("queued launch %0d", j));
      apply_copy(32'h800, dst, 32'd8, 32'd0, 32'd0, 32'd1);
      exp_id = exp_id + 32'd1;
    end
    reg_write(REG_DST, 32'hb00);
    idle(2);
    read_check(REG_NEXT_ID, 32'd0, "launch into full FIFO");
    read_check(REG_STATUS, 32'd1, "STATUS busy while stalled");
    grant_hold = 1'b0;
    wait_done_id(exp_id - 32'd1);
    read_check(REG_STATUS, 32'd0, "STATUS after drain");
    compare_memory("queued copies");
    report_test("queueing", mark);
  endtask

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i[9:0]]     = {16'hd0a5, 6'h00, i[9:0]};
      exp_mem[i[9:0]] = {16'hd0a5, 6'h00, i[9:0]};
    end
    wait (arst_n === 1'b1);
    @(negedge clk);
    test_register_readback();
    test_copy_1d();
    test_copy_2d();
    test_launch_reject();
    test_queueing();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dma_subsys.f
src/dma_pkg.sv
src/dma_burst_if.sv
src/dma_reg_frontend.sv
src/dma_transfer_id_gen.sv
src/dma_job_fifo.sv
src/dma_nd_midend.sv
src/dma_backend.sv
src/dma_subsys.sv
verification/tb_clk_gen.sv
verification/tb_dma_subsys.sv

// File: Makefile
TOP := tb_dma_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f dma_subsys.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

# Pass or fail is taken from the log
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
